/* common/mpb_pkg.sv */
package mpb_pkg;

	// ------------------------------
	// Register bus widths
	// ------------------------------
	localparam int ADDR_W = 7;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;     // Register address
	typedef logic [DATA_W-1:0] data_t;     // Register data

	// ------------------------------
	// Register space
	// ------------------------------
	localparam int REG_NUM = 128;

	// The last word of the space holds the silicon revision
	localparam addr_t REVID_ADDR  = 7'h7F;
	localparam data_t REVID_VALUE = 8'h27;

	// ------------------------------
	// Arbiter issue state
	// ------------------------------
	// Which slot drives the register bus in the current cycle.
	// The PD protocol slot always wins when it holds a request.
	typedef enum logic [1:0] {
		GNT_IDLE = 2'd0,                 // Nothing issued
		GNT_I2C  = 2'd1,                 // Slot 0 on the bus
		GNT_PRL  = 2'd2                  // Slot 1 on the bus
	} grant_t;

endpackage

/* source/sfr_bank.sv */
`timescale 1ns/10ps

module sfr_bank import mpb_pkg::*; (
	input  logic  i_clk,
	input  logic  i_rst,
	input  logic  i_we,                  // Single cycle write
	input  logic  i_re,                  // Single cycle read
	input  addr_t i_addr,
	input  data_t i_wdat,
	output data_t o_rdat,                // Valid with o_rrdy
	output logic  o_rrdy
);

	data_t regs [REG_NUM];               // Register storage
	logic  hit_revid;
	data_t rd_mux;

	// Revision word is fixed in hardware
	assign hit_revid = (i_addr == REVID_ADDR);

	// ------------------------------
	// Write port
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int n = 0; n < REG_NUM; n++) begin
				regs[n] <= '0;
			end
		end else if (i_we && !hit_revid) begin
			regs[i_addr] <= i_wdat;
		end
	end

	// ------------------------------
	// Read port
	// ------------------------------
	always_comb begin
		if (hit_revid) begin
			rd_mux = REVID_VALUE;
		end else begin
			rd_mux = regs[i_addr];
		end
	end

	// Data is held between reads
	always_ff @(posedge i_clk) begin
		if (i_re) begin
			o_rdat <= rd_mux;
		end
	end

	// Ready follows the read strobe by one cycle
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_rrdy <= 1'b0;
		end else begin
			o_rrdy <= i_re;
		end
	end

endmodule

/* source/mpb_arbiter.sv */
`timescale 1ns/10ps

module mpb_arbiter import mpb_pkg::*; (
	input  logic  i_clk,
	input  logic  i_rst,

	// ------------------------------
	// Initiator 0 (I2C slave)
	// ------------------------------
	input  logic  i_rd_0,                // Read strobe
	input  logic  i_wr_0,                // Write strobe
	input  addr_t i_addr_0,
	input  data_t i_wdat_0,
	output logic  o_busy_0,              // Slot 0 occupied
	output logic  o_rrdy_0,              // Read data pulse

	// ------------------------------
	// Initiator 1 (PD protocol)
	// ------------------------------
	input  logic  i_rd_1,                // Read strobe
	input  logic  i_wr_1,                // Write strobe
	input  addr_t i_addr_1,
	input  data_t i_wdat_1,
	output logic  o_busy_1,              // Slot 1 occupied
	output logic  o_rrdy_1,              // Read data pulse

	output data_t o_rdat,                // Shared by both initiators

	// ------------------------------
	// Register bus to the bank
	// ------------------------------
	output logic  o_bus_we,
	output logic  o_bus_re,
	output addr_t o_bus_addr,
	output data_t o_bus_wdat,
	input  data_t i_bus_rdat,
	input  logic  i_bus_rrdy             // One cycle after o_bus_re
);

	// Request side gathered into arrays, index equals initiator number
	logic  [1:0] fill;                   // Strobe in this cycle
	logic  [1:0] req_wr;                 // Strobe is a write
	addr_t       req_addr [2];
	data_t       req_wdat [2];

	// Holding slots
	logic  [1:0] slot_full;
	logic  [1:0] slot_wr;                // 1 = write, 0 = read
	addr_t       slot_addr [2];
	data_t       slot_wdat [2];

	logic  [1:0] issue;                  // Slot on the bus this cycle
	logic  [1:0] full_nxt;
	logic        bus_sel;                // Payload select for the bus
	grant_t      grant_q;
	grant_t      grant_nxt;
	logic        rd_owner;               // Initiator of the pending read

	assign fill[0]     = i_rd_0 | i_wr_0;
	assign fill[1]     = i_rd_1 | i_wr_1;
	assign req_wr[0]   = i_wr_0;
	assign req_wr[1]   = i_wr_1;
	assign req_addr[0] = i_addr_0;
	assign req_addr[1] = i_addr_1;
	assign req_wdat[0] = i_wdat_0;
	assign req_wdat[1] = i_wdat_1;

	// ------------------------------
	// Grant and slot occupancy
	// ------------------------------
	always_comb begin
		issue[0] = (grant_q == GNT_I2C);
		issue[1] = (grant_q == GNT_PRL);

		// An issued slot drains at the coming edge
		for (int n = 0; n < 2; n++) begin
			full_nxt[n] = fill[n] | (slot_full[n] & ~issue[n]);
		end

		// Fixed priority, protocol side first
		if (full_nxt[1]) begin
			grant_nxt = GNT_PRL;
		end else if (full_nxt[0]) begin
			grant_nxt = GNT_I2C;
		end else begin
			grant_nxt = GNT_IDLE;
		end
	end

	// The grant is computed from the next occupancy so that a slot
	// filled at one edge can drive the bus in the following cycle
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			slot_full <= 2'b00;
			grant_q   <= GNT_IDLE;
		end else begin
			slot_full <= full_nxt;
			grant_q   <= grant_nxt;
		end
	end

	// Slot payload captured with the strobe
	always_ff @(posedge i_clk) begin
		for (int n = 0; n < 2; n++) begin
			if (fill[n]) begin
				slot_wr[n]   <= req_wr[n];
				slot_addr[n] <= req_addr[n];
				slot_wdat[n] <= req_wdat[n];
			end
		end
	end

	// ------------------------------
	// Register bus drive
	// ------------------------------
	assign bus_sel    = issue[1];
	assign o_bus_we   = |(issue & slot_wr);
	assign o_bus_re   = |(issue & ~slot_wr);
	assign o_bus_addr = slot_addr[bus_sel];
	assign o_bus_wdat = slot_wdat[bus_sel];

	// ------------------------------
	// Read return steering
	// ------------------------------
	// Bank latency is one cycle, so one owner bit is enough
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			rd_owner <= 1'b0;
		end else if (o_bus_re) begin
			rd_owner <= bus_sel;
		end
	end

	assign o_rrdy_0 = i_bus_rrdy & ~rd_owner;
	assign o_rrdy_1 = i_bus_rrdy & rd_owner;
	assign o_rdat   = i_bus_rdat;        // Qualified by the ready pulses

	// Back-pressure seen by the initiators
	assign o_busy_0 = slot_full[0];
	assign o_busy_1 = slot_full[1];

endmodule

/* source/mpb_core.sv */
`timescale 1ns/10ps

module mpb_core import mpb_pkg::*; (
	input  logic  i_clk,
	input  logic  i_rst,

	// ------------------------------
	// I2C slave side
	// ------------------------------
	input  logic  i_rd_0,
	input  logic  i_wr_0,
	input  addr_t i_addr_0,
	input  data_t i_wdat_0,

	// ------------------------------
	// PD protocol side
	// ------------------------------
	input  logic  i_rd_1,
	input  logic  i_wr_1,
	input  addr_t i_addr_1,
	input  data_t i_wdat_1,

	output logic  o_busy_0,
	output logic  o_busy_1,
	output logic  o_rrdy_0,
	output logic  o_rrdy_1,
	output data_t o_rdat
);

	// Internal register bus
	logic  bus_we;
	logic  bus_re;
	addr_t bus_addr;
	data_t bus_wdat;
	data_t bus_rdat;
	logic  bus_rrdy;

	mpb_arbiter u0_mpb_arbiter (
		.i_clk		(i_clk),
		.i_rst		(i_rst),
		.i_rd_0		(i_rd_0),	// From initiator 0
		.i_wr_0		(i_wr_0),
		.i_addr_0	(i_addr_0),
		.i_wdat_0	(i_wdat_0),
		.o_busy_0	(o_busy_0),
		.o_rrdy_0	(o_rrdy_0),
		.i_rd_1		(i_rd_1),	// From initiator 1
		.i_wr_1		(i_wr_1),
		.i_addr_1	(i_addr_1),
		.i_wdat_1	(i_wdat_1),
		.o_busy_1	(o_busy_1),
		.o_rrdy_1	(o_rrdy_1),
		.o_rdat		(o_rdat),	// To both initiators
		.o_bus_we	(bus_we),	// To register bank
		.o_bus_re	(bus_re),
		.o_bus_addr	(bus_addr),
		.o_bus_wdat	(bus_wdat),
		.i_bus_rdat	(bus_rdat),	// From register bank
		.i_bus_rrdy	(bus_rrdy)
	); // u0_mpb_arbiter

	sfr_bank u0_sfr_bank (
		.i_clk		(i_clk),
		.i_rst		(i_rst),
		.i_we		(bus_we),
		.i_re		(bus_re),
		.i_addr		(bus_addr),
		.i_wdat		(bus_wdat),
		.o_rdat		(bus_rdat),
		.o_rrdy		(bus_rrdy)
	); // u0_sfr_bank

endmodule

/* testbench/mpb_assertions.sv */
`timescale 1ns/10ps

module mpb_assertions import mpb_pkg::*; (
	input logic       i_clk,
	input logic       i_rst,
	input logic       i_rd_0,
	input logic       i_wr_0,
	input logic       i_busy_0,
	input logic       i_rrdy_0,
	input logic       i_rd_1,
	input logic       i_wr_1,
	input logic       i_busy_1,
	input logic       i_rrdy_1,
	input logic       i_bus_we,
	input logic       i_bus_re,
	input logic [1:0] i_slot_full,
	input grant_t     i_grant
);

	int fail_count = 0;                  // Failed assertion count

	// Initiators hold off while their slot is occupied
	a_strobe_idle_0: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_rd_0 || i_wr_0) |-> !i_busy_0)
		else begin
			$error("strobe on initiator 0 while its slot is busy");
			fail_count++;
		end

	a_strobe_idle_1: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_rd_1 || i_wr_1) |-> !i_busy_1)
		else begin
			$error("strobe on initiator 1 while its slot is busy");
			fail_count++;
		end

	a_rrdy_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_rrdy_0 && i_rrdy_1))
		else begin
			$error("both ready pulses high in one cycle");
			fail_count++;
		end

	a_bus_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_bus_we && i_bus_re))
		else begin
			$error("bus write and bus read high in one cycle");
			fail_count++;
		end

	// Protocol slot has priority whenever it holds a request
	a_prl_first: assert property (@(posedge i_clk) disable iff (i_rst)
		i_slot_full[1] |-> (i_grant == GNT_PRL))
		else begin
			$error("slot 1 full but not granted");
			fail_count++;
		end

endmodule

bind mpb_arbiter mpb_assertions u0_mpb_assertions (
	.i_clk		(i_clk),
	.i_rst		(i_rst),
	.i_rd_0		(i_rd_0),
	.i_wr_0		(i_wr_0),
	.i_busy_0	(o_busy_0),
	.i_rrdy_0	(o_rrdy_0),
	.i_rd_1		(i_rd_1),
	.i_wr_1		(i_wr_1),
	.i_busy_1	(o_busy_1),
	.i_rrdy_1	(o_rrdy_1),
	.i_bus_we	(o_bus_we),
	.i_bus_re	(o_bus_re),
	.i_slot_full	(slot_full),
	.i_grant	(grant_q)
);

/* testbench/tb_mpb_core.sv */
`timescale 1ns/10ps

module tb_mpb_core import mpb_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 16;
	localparam int VEC_MAX    = 64;
	localparam int VEC_FIELDS = 6;       // test, who, op, addr, wdat, exp

	logic        i_clk;
	logic        i_rst;
	logic        i_rd_0;
	logic        i_wr_0;
	addr_t       i_addr_0;
	data_t       i_wdat_0;
	logic        i_rd_1;
	logic        i_wr_1;
	addr_t       i_addr_1;
	data_t       i_wdat_1;
	logic        o_busy_0;
	logic        o_busy_1;
	logic        o_rrdy_0;
	logic        o_rrdy_1;
	data_t       o_rdat;

	logic [7:0]  vec_mem [VEC_MAX*VEC_FIELDS];
	data_t       model [REG_NUM];        // Reference register space
	logic [31:0] lfsr = 32'h27f0cb86;
	logic        vec_loaded = 1'b0;
	int          vec_count;
	int          err_count;
	int          test_errs;
	int          cur_test;

	mpb_core uut (.*);

	always #(CLK_PERIOD/2) i_clk = ~i_clk;

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic next_cycle();
		@(posedge i_clk);
		#2;                              // Drive and sample point
	endtask

	task automatic drive_idle();
		i_rd_0 = 1'b0;
		i_wr_0 = 1'b0;
		i_rd_1 = 1'b0;
		i_wr_1 = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", name, actual, expected);
			err_count++;
			test_errs++;
		end
	endtask

	task automatic report_fault(input string text);
		$display("Failure in test %0d: %s", cur_test, text);
		err_count++;
		test_errs++;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
	endfunction

	task automatic random_bit(output logic b);
		b    = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	function automatic data_t model_read(input addr_t addr);
		return (addr == REVID_ADDR) ? REVID_VALUE : model[addr];
	endfunction

	task automatic model_write(input addr_t addr, input data_t wdat);
		if (addr != REVID_ADDR) begin
			model[addr] = wdat;
		end
	endtask

	task automatic finish_test();
		$display("Test %0d done, %0d errors", cur_test, test_errs);
	endtask

	// who 0 or 1 is one initiator, 2 is both in the same cycle
	task automatic run_vector(input int who, input logic wr, input addr_t addr,
		input data_t wdat, input data_t exp);
		logic [1:0] use_i;
		logic [1:0] got;
		logic       done;
		int         lat [2];
		int         fin;
		use_i  = (who == 2) ? 2'b11 : (2'b01 << who);
		got    = 2'b00;
		done   = 1'b0;
		lat[0] = 0;
		lat[1] = 0;
		fin    = 0;
		while ((o_busy_0 & use_i[0]) | (o_busy_1 & use_i[1])) begin
			next_cycle();
		end
		if (!wr) begin
			check_value("vector expected data", exp, model_read(addr));
		end
		if (use_i[0]) begin
			i_rd_0   = ~wr;
			i_wr_0   = wr;
			i_addr_0 = addr;
			i_wdat_0 = wdat;
		end
		if (use_i[1]) begin
			i_rd_1   = ~wr;
			i_wr_1   = wr;
			i_addr_1 = addr;
			i_wdat_1 = (who == 2) ? ~wdat : wdat;
		end
		// Initiator 1 is issued first, so initiator 0 lands last
		if (wr && use_i[1]) begin
			model_write(addr, i_wdat_1);
		end
		if (wr && use_i[0]) begin
			model_write(addr, wdat);
		end
		next_cycle();
		drive_idle();
		// Slots hold the request right after the strobe edge
		if (use_i[0]) begin
			check_value("o_busy_0", o_busy_0, 1);
		end
		if (use_i[1]) begin
			check_value("o_busy_1", o_busy_1, 1);
		end
		for (int cyc = 1; cyc < 6 && !done; cyc++) begin
			if (o_rrdy_0 && (wr || !use_i[0] || got[0])) begin
				report_fault("unexpected ready pulse on initiator 0");
			end else if (o_rrdy_0) begin
				check_value("o_rdat", o_rdat, exp);
				lat[0] = cyc;
				got[0] = 1'b1;
			end
			if (o_rrdy_1 && (wr || !use_i[1] || got[1])) begin
				report_fault("unexpected ready pulse on initiator 1");
			end else if (o_rrdy_1) begin
				check_value("o_rdat", o_rdat, exp);
				lat[1] = cyc;
				got[1] = 1'b1;
			end
			done = wr ? !((o_busy_0 & use_i[0]) | (o_busy_1 & use_i[1])) : (got == use_i);
			if (done) begin
				fin = cyc;
			end else begin
				next_cycle();
			end
		end
		if (!done) begin
			report_fault("register bus gave no response");
		end else if (!wr && use_i[1]) begin
			check_value("o_rrdy_1 latency", lat[1], 2);
		end
		if (done && !wr && use_i[0]) begin
			check_value("o_rrdy_0 latency", lat[0], use_i[1] ? 3 : 2);
		end
		if (done && wr) begin
			check_value("o_busy release cycle", fin, (use_i == 2'b11) ? 3 : 2);
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		logic b0;
		logic b1;
		int   base;
		i_clk     = 1'b0;
		i_rst     = 1'b1;
		i_addr_0  = '0;
		i_wdat_0  = '0;
		i_addr_1  = '0;
		i_wdat_1  = '0;
		drive_idle();
		err_count = 0;
		test_errs = 0;
		cur_test  = 1;
		for (int n = 0; n < REG_NUM; n++) begin
			model[n] = '0;
		end
		$readmemh("testbench/mpb_vectors.txt", vec_mem);
		vec_count = 0;
		while (vec_count < VEC_MAX && vec_mem[vec_count*VEC_FIELDS] != 8'h00) begin
			vec_count++;
		end
		vec_loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge i_clk);
		#2;
		i_rst = 1'b0;
		next_cycle();
		check_value("o_busy_0", o_busy_0, 0);
		check_value("o_busy_1", o_busy_1, 0);
		check_value("o_rrdy_0", o_rrdy_0, 0);
		check_value("o_rrdy_1", o_rrdy_1, 0);
		for (int i = 0; i < vec_count; i++) begin
			base = i * VEC_FIELDS;
			if (vec_mem[base] != cur_test) begin
				finish_test();
				cur_test  = vec_mem[base];
				test_errs = 0;
			end
			random_bit(b0);
			random_bit(b1);
			repeat ({b1, b0}) next_cycle();  // 0 to 3 idle cycles
			run_vector(vec_mem[base+1], vec_mem[base+2][0], vec_mem[base+3][ADDR_W-1:0],
				vec_mem[base+4], vec_mem[base+5]);
		end
		finish_test();
		$display("Summary: %0d vectors, %0d check errors, %0d assertion failures",
			vec_count, err_count, uut.u0_mpb_arbiter.u0_mpb_assertions.fail_count);
		if (err_count + uut.u0_mpb_arbiter.u0_mpb_assertions.fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Watchdog sized from the vector count
	initial begin
		wait (vec_loaded);
		#((vec_count * 8 + RST_CYCLES) * CLK_PERIOD);
		$display("Timeout: the vectors did not complete in the allowed time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* testbench/mpb_vectors.txt */
// Columns: test, initiator (0, 1, 2 = both), op (0 rd, 1 wr), addr, wdat, expected rdat
// For initiator 2, initiator 1 uses the inverted write data; a test number of 00 ends the list
01 00 00 05 00 00
01 01 00 05 00 00
01 00 00 40 00 00
01 01 00 7E 00 00
02 00 01 10 A5 00
02 01 00 10 00 A5
02 01 01 22 3C 00
02 00 00 22 00 3C
02 00 01 00 FF 00
02 01 00 00 00 FF
03 00 00 10 00 A5
03 01 00 22 00 3C
03 00 00 7E 00 00
04 02 01 33 5A 00
04 00 00 33 00 5A
04 02 00 33 00 5A
04 02 00 10 00 A5
05 00 00 7F 00 27
05 01 01 7F 99 00
05 00 00 7F 00 27
05 02 01 7F 11 00
05 01 00 7F 00 27
00 00 00 00 00 00

/* all.f */
common/mpb_pkg.sv
source/sfr_bank.sv
source/mpb_arbiter.sv
source/mpb_core.sv
testbench/mpb_assertions.sv
testbench/tb_mpb_core.sv
